// ==== adpcm/adpcm_ctrl.sv ====
`timescale 1ns/1ps

module adpcm_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick,
    // cpu side
    input  logic [7:0]         cpu_dout,
    input  logic               oki_wrn,     // active low, one cycle
    output logic [7:0]         oki_dout,
    // sample rom
    output snd_pkg::rom_addr_t adpcm_addr,
    output logic               adpcm_cs,
    input  logic [7:0]         adpcm_data,
    input  logic               adpcm_ok,
    // to the decoder
    output snd_pkg::nibble_t   nib,
    output logic               nib_valid,
    output logic               restart
);
    import snd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        HIGH_NIB,
        LOW_NIB
    } state_t;

    state_t               state;
    logic [7:0]           rom_byte;   // byte being played out
    logic [PHRASE_AW-1:0] left;       // bytes still to fetch after this one
    logic                 cpu_wr;
    logic                 busy;

    assign cpu_wr   = ~oki_wrn;
    assign busy     = state != IDLE;
    assign adpcm_cs = state == FETCH;   // held until the rom answers
    assign oki_dout = {7'd0, busy};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            adpcm_addr <= '0;
            left       <= '0;
            nib_valid  <= 1'b0;
            restart    <= 1'b0;
        end else begin
            nib_valid <= 1'b0;
            restart   <= 1'b0;
            if (cpu_wr) begin
                // cpu commands win over playback
                if (cpu_dout[7]) begin
                    adpcm_addr <= rom_addr_t'(cpu_dout[6:0]) << PHRASE_AW;
                    left       <= PHRASE_AW'(PHRASE_BYTES - 1);
                    restart    <= 1'b1;
                    state      <= FETCH;
                end else begin
                    state <= IDLE;   // stop
                end
            end else begin
                case (state)
                    FETCH: begin
                        if (adpcm_ok) begin
                            state <= HIGH_NIB;
                        end
                    end
                    HIGH_NIB: begin
                        if (tick) begin
                            nib_valid <= 1'b1;
                            state     <= LOW_NIB;
                        end
                    end
                    LOW_NIB: begin
                        if (tick) begin
                            nib_valid <= 1'b1;
                            if (left == '0) begin
                                state <= IDLE;   // phrase done
                            end else begin
                                adpcm_addr <= adpcm_addr + 1'b1;
                                left       <= left - 1'b1;
                                state      <= FETCH;
                            end
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // data path, nib only matters while nib_valid is high
    always_ff @(posedge clk) begin
        if (adpcm_cs && adpcm_ok) begin
            rom_byte <= adpcm_data;
        end
        if (tick) begin
            nib <= (state == HIGH_NIB) ? rom_byte[7:4] : rom_byte[3:0];
        end
    end

endmodule

// ==== adpcm/adpcm_decoder.sv ====
`timescale 1ns/1ps

module adpcm_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  snd_pkg::nibble_t nib,
    input  logic             nib_valid,
    input  logic             restart,
    output snd_pkg::sample_t adpcm_snd
);
    import snd_pkg::*;

    logic signed [16:0] delta;   // one guard bit over sample_t
    logic signed [16:0] sum;
    logic               sat;
    sample_t            sum_sat;

    // fixed step, the nibble is the delta itself
    assign delta = 17'(nib) <<< DELTA_SHIFT;
    assign sum   = 17'(adpcm_snd) + delta;

    // overflow when the guard bit disagrees with the sign
    assign sat = sum[16] ^ sum[15];

    always_comb begin
        if (sat) begin
            sum_sat = {sum[16], {15{~sum[16]}}};
        end else begin
            sum_sat = sum[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            adpcm_snd <= '0;
        end else if (restart) begin
            adpcm_snd <= '0;   // new phrase starts from silence
        end else if (nib_valid) begin
            adpcm_snd <= sum_sat;
        end
    end

endmodule

// ==== common/snd_pkg.sv ====
package snd_pkg;

    // audio sample widths
    typedef logic signed [15:0] sample_t;   // fm, opl, adpcm and mixed channels
    typedef logic        [9:0]  psg_t;      // raw psg level, unsigned
    typedef logic signed [10:0] psg_ac_t;   // psg after dc removal

    // 4.4 fixed point, 0x10 is unity
    typedef logic [7:0] gain_t;

    // sample rom byte address
    typedef logic [17:0] rom_addr_t;

    // one adpcm code, read as -8..+7
    typedef logic signed [3:0] nibble_t;

    // fixed channel gains
    localparam gain_t OPL_GAIN = 8'h10;
    localparam gain_t PCM_GAIN = 8'h10;
    localparam gain_t PSG_GAIN = 8'h10;

    // fx gain tables indexed by fxlevel
    localparam gain_t FX_GAIN_STD [0:3] = '{8'h18, 8'h20, 8'h28, 8'h30};
    localparam gain_t FX_GAIN_ALT [0:3] = '{8'h08, 8'h10, 8'h18, 8'h20};

    // adpcm phrase layout
    localparam int PHRASE_BYTES = 64;
    localparam int PHRASE_AW    = $clog2(PHRASE_BYTES);   // page offset bits

    // opl enables per adpcm tick
    localparam int ADPCM_DIV = 3;
    localparam int ADPCM_CW  = $clog2(ADPCM_DIV);

    // nibble weight in the decoder
    localparam int DELTA_SHIFT = 8;

    // fraction bits of the psg dc average
    localparam int DC_FRAC = 4;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module snd_board_tb \
    -f snd_board.f \
    -Mdir obj_dir -o snd_board_sim

./obj_dir/snd_board_sim > sim.log 2>&1
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi

// ==== snd_board.f ====
common/snd_pkg.sv
verilog/adpcm_tick.sv
adpcm/adpcm_ctrl.sv
adpcm/adpcm_decoder.sv
verilog/psg_dc_block.sv
verilog/snd_mixer.sv
verilog/snd_board.sv
testbench/snd_board_tb.sv

// ==== testbench/snd_board_tb.sv ====
`timescale 1ns/1ps

module snd_board_tb;
    import snd_pkg::*;

    typedef enum {MIX, PLAY, ABORT} kind_t;

    typedef struct {
        string      name;
        kind_t      kind;
        int         reps;     // sample pulses checked
        logic [1:0] fx;
        logic       en_fm;
        logic       en_psg;
        sample_t    opn;
        sample_t    opl;
        psg_t       psg;
        logic [7:0] cmd;      // adpcm command
    } row_t;

    localparam int NUM_ROWS      = 12;
    localparam int PHRASE_CYCLES = 64 * 2 * 3 * 2;   // bytes x nibbles x opl enables x clocks
    localparam int MAX_CYCLES    = 4 * (2 * PHRASE_CYCLES + NUM_ROWS * 40);
    localparam int FX_STD_TB [4] = '{24, 32, 40, 48};
    localparam int FX_ALT_TB [4] = '{8, 16, 24, 32};

    logic       clk;
    logic       rst_n;
    logic       cen_opl;
    logic       cen_opn;
    logic [7:0] cpu_dout;
    logic       oki_wrn;
    logic [7:0] oki_dout;
    rom_addr_t  adpcm_addr;
    logic       adpcm_cs;
    logic [7:0] adpcm_data;
    logic       adpcm_ok;
    sample_t    opn_snd;
    sample_t    opl_snd;
    psg_t       psg_snd;
    logic [1:0] fxlevel;
    logic       enable_fm;
    logic       enable_psg;
    sample_t    snd;
    sample_t    snd_alt;
    logic       sample;
    logic       peak;
    logic       peak_alt;

    int        cyc;
    int        errors;
    int        checks;
    int        avg_m;      // dc average model with 4 fraction bits
    int        acc_m;      // model of the adpcm accumulator
    int        rom_wait;
    bit        exp_pulse;
    sample_t   exp_std;
    sample_t   exp_alt;
    bit        exp_peak;
    bit        exp_peak_alt;
    rom_addr_t addr_q [$];  // rom addresses in the order they were served
    row_t      rows [NUM_ROWS];

    snd_board #(.ALT_FX(0)) i_snd_board (.*);

    // second board runs the alternate fx table on the same inputs
    snd_board #(.ALT_FX(1)) i_snd_board_alt (
        .*,
        .oki_dout   (),
        .adpcm_addr (),
        .adpcm_cs   (),
        .snd        (snd_alt),
        .sample     (),
        .peak       (peak_alt)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc     <= cyc + 1;
        cen_opl <= cyc[0];
        cen_opn <= cyc[1:0] == 2'b11;
    end

    always @(posedge clk) begin
        if (cyc >= MAX_CYCLES) begin
            $display("timeout at cycle %0d before the tests finished", cyc);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [7:0] rom_byte(input int addr);
        return 8'((addr * 37 + 11) % 256);
    endfunction

    // whole phrase through the fixed step decoder
    function automatic int phrase_ref(input int page);
        int         acc;
        int         n;
        logic [7:0] b;
        acc = 0;
        for (int i = 0; i < 128; i++) begin
            b = rom_byte(page * 64 + i / 2);
            n = (i % 2 == 0) ? int'(b[7:4]) : int'(b[3:0]);   // high nibble first
            if (n > 7) n -= 16;
            acc += n * 256;
            if (acc > 32767) acc = 32767;
            if (acc < -32768) acc = -32768;
        end
        return acc;
    endfunction

    function automatic sample_t mix_ref(input bit alt, input logic [1:0] fx, input logic en_fm,
                                        input logic en_psg, input int opn, input int opl,
                                        input int pcm, input int psg_ac, output bit sat);
        int fx_g;
        int sum;
        fx_g = alt ? FX_ALT_TB[fx] : FX_STD_TB[fx];
        sum  = 0;
        if (en_fm) sum += (opn * fx_g) >>> 4;
        sum += (opl * 16) >>> 4;
        sum += (pcm * 16) >>> 4;
        if (en_psg) sum += (psg_ac * 16) >>> 4;
        sat = sum > 32767 || sum < -32768;
        if (sum > 32767) sum = 32767;
        if (sum < -32768) sum = -32768;
        return sample_t'(sum);
    endfunction

    // reference model clocked on the same edges as the mixer
    always @(posedge clk) begin : ref_model
        int psg_ac_m;
        if (rst_n && sample !== exp_pulse) begin
            errors++;
            $display("sample pulse out of step with cen_opn at cycle %0d", cyc);
        end
        exp_pulse = rst_n && cen_opn;
        if (!rst_n) begin
            avg_m = 0;
        end else if (cen_opn) begin
            psg_ac_m = int'(psg_snd) - (avg_m >>> 4);
            exp_std  = mix_ref(1'b0, fxlevel, enable_fm, enable_psg, int'(opn_snd),
                               int'(opl_snd), acc_m, psg_ac_m, exp_peak);
            exp_alt  = mix_ref(1'b1, fxlevel, enable_fm, enable_psg, int'(opn_snd),
                               int'(opl_snd), acc_m, psg_ac_m, exp_peak_alt);
            avg_m += ((int'(psg_snd) << 4) - avg_m) >>> 4;
        end
    end

    // sample rom with 0 to 3 cycles of wait
    always @(posedge clk) begin
        if (adpcm_cs !== 1'b1 || adpcm_ok) begin
            if (adpcm_cs === 1'b1) begin
                addr_q.push_back(adpcm_addr);   // byte taken at this edge
            end
            adpcm_ok <= 1'b0;
            rom_wait = -1;
        end else begin
            if (rom_wait < 0) rom_wait = $urandom % 4;
            if (rom_wait == 0) begin
                adpcm_data <= rom_byte(int'(adpcm_addr));
                adpcm_ok   <= 1'b1;
            end else begin
                rom_wait--;
            end
        end
    end

    task automatic check_sample(input string name, input sample_t exp_v, input sample_t act);
        checks++;
        if (act !== exp_v) begin
            errors++;
            $display("mismatch %s: expected %0d actual %0d", name, exp_v, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act);
        checks++;
        if (act !== exp_v) begin
            errors++;
            $display("mismatch %s: expected %b actual %b", name, exp_v, act);
        end
    endtask

    task automatic check_addr(input string name, input rom_addr_t exp_v, input rom_addr_t act);
        checks++;
        if (act !== exp_v) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, exp_v, act);
        end
    endtask

    task automatic report(input string name, input int e0);
        if (errors == e0) $display("test %s ok", name);
        else $display("test %s failed with %0d errors", name, errors - e0);
    endtask

    task automatic wait_sample();
        @(negedge clk);
        while (sample !== 1'b1) @(negedge clk);
    endtask

    task automatic apply(input row_t r);
        @(posedge clk);
        fxlevel    <= r.fx;
        enable_fm  <= r.en_fm;
        enable_psg <= r.en_psg;
        opn_snd    <= r.opn;
        opl_snd    <= r.opl;
        psg_snd    <= r.psg;
    endtask

    task automatic cpu_write(input logic [7:0] cmd);
        @(posedge clk);
        cpu_dout <= cmd;
        oki_wrn  <= 1'b0;
        @(posedge clk);
        oki_wrn  <= 1'b1;   // the DUT takes the strobe at this edge
        @(negedge clk);
    endtask

    task automatic run_mix(input row_t r);
        apply(r);
        wait_sample();   // may still carry the old inputs
        repeat (r.reps) begin
            wait_sample();
            check_sample(r.name, exp_std, snd);
            check_sample({r.name, " alt"}, exp_alt, snd_alt);
            check_flag({r.name, " peak"}, exp_peak, peak);
            check_flag({r.name, " alt peak"}, exp_peak_alt, peak_alt);
        end
    endtask

    task automatic run_play(input row_t r);
        int page;
        page = int'(r.cmd[6:0]);
        addr_q.delete();
        acc_m = phrase_ref(page);
        apply(r);
        cpu_write(r.cmd);
        check_flag({r.name, " busy"}, 1'b1, oki_dout[0]);
        check_flag({r.name, " status zero bits"}, 1'b0, |oki_dout[7:1]);
        while (oki_dout[0] === 1'b1) @(negedge clk);
        wait_sample();
        wait_sample();   // last nibble lands after busy falls
        check_sample(r.name, sample_t'(acc_m), snd);
        if (addr_q.size() != 64) begin
            errors++;
            $display("%s: the rom served %0d bytes instead of 64", r.name, addr_q.size());
        end else begin
            for (int i = 0; i < 64; i++) begin
                check_addr({r.name, " addr"}, rom_addr_t'(page * 64 + i), addr_q[i]);
            end
        end
    endtask

    task automatic run_abort(input row_t r);
        addr_q.delete();
        apply(r);
        cpu_write(r.cmd);
        while (addr_q.size() < 8) @(negedge clk);
        cpu_write(8'h00);   // stop
        check_flag({r.name, " busy"}, 1'b0, oki_dout[0]);
        check_flag({r.name, " cs"}, 1'b0, adpcm_cs);
        addr_q.delete();
    endtask

    task automatic fill_rows();
        rows[0]  = '{"fx level 0", MIX, 2, 2'd0, 1'b1, 1'b0, 16'sd1000, 16'sd0, 10'd0, 8'h00};
        rows[1]  = '{"fx level 1", MIX, 2, 2'd1, 1'b1, 1'b0, -16'sd1234, 16'sd0, 10'd0, 8'h00};
        rows[2]  = '{"fx level 2", MIX, 2, 2'd2, 1'b1, 1'b0, 16'sd777, 16'sd0, 10'd0, 8'h00};
        rows[3]  = '{"fx level 3", MIX, 2, 2'd3, 1'b1, 1'b0, -16'sd3000, 16'sd0, 10'd0, 8'h00};
        rows[4]  = '{"fm off", MIX, 2, 2'd3, 1'b0, 1'b0, 16'sd5000, 16'sd2000, 10'd0, 8'h00};
        rows[5]  = '{"psg off", MIX, 2, 2'd1, 1'b1, 1'b0, 16'sd0, -16'sd1500, 10'd500, 8'h00};
        rows[6]  = '{"clip high", MIX, 2, 2'd3, 1'b1, 1'b0, 16'sd20000, 16'sd20000, 10'd0, 8'h00};
        rows[7]  = '{"clip low", MIX, 2, 2'd3, 1'b1, 1'b0, -16'sd20000, -16'sd20000, 10'd0, 8'h00};
        rows[8]  = '{"peak clear", MIX, 2, 2'd0, 1'b1, 1'b0, 16'sd100, 16'sd100, 10'd0, 8'h00};
        rows[9]  = '{"psg dc", MIX, 8, 2'd0, 1'b0, 1'b1, 16'sd0, 16'sd0, 10'd600, 8'h00};
        rows[10] = '{"play page", PLAY, 0, 2'd0, 1'b0, 1'b0, 16'sd0, 16'sd0, 10'd0, 8'h85};
        rows[11] = '{"stop early", ABORT, 0, 2'd0, 1'b0, 1'b0, 16'sd0, 16'sd0, 10'd0, 8'h82};
    endtask

    initial begin
        int e0;
        void'($urandom(17));
        clk        = 1'b0;
        rst_n      = 1'b0;
        cen_opl    = 1'b0;
        cen_opn    = 1'b0;
        cpu_dout   = 8'h00;
        oki_wrn    = 1'b1;
        adpcm_data = 8'h00;
        adpcm_ok   = 1'b0;
        opn_snd    = '0;
        opl_snd    = '0;
        psg_snd    = '0;
        fxlevel    = 2'd0;
        enable_fm  = 1'b0;
        enable_psg = 1'b0;
        cyc        = 0;
        errors     = 0;
        checks     = 0;
        acc_m      = 0;
        fill_rows();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        e0 = errors;
        check_sample("reset snd", 16'sd0, snd);
        check_flag("reset peak", 1'b0, peak);
        check_flag("reset cs", 1'b0, adpcm_cs);
        check_flag("reset busy", 1'b0, oki_dout[0]);
        report("reset", e0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            e0 = errors;
            case (rows[i].kind)
                MIX:     run_mix(rows[i]);
                PLAY:    run_play(rows[i]);
                default: run_abort(rows[i]);
            endcase
            report(rows[i].name, e0);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog/adpcm_tick.sv ====
`timescale 1ns/1ps

module adpcm_tick (
    input  logic clk,
    input  logic rst_n,
    input  logic cen_opl,
    output logic tick
);
    import snd_pkg::*;

    logic [ADPCM_CW-1:0] cnt;   // opl enables seen in this tick period
    logic                wrap;

    assign wrap = cnt == ADPCM_CW'(ADPCM_DIV - 1);

    // pulse on the enable that wraps the count
    assign tick = cen_opl & wrap;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cen_opl) begin
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/psg_dc_block.sv ====
`timescale 1ns/1ps

module psg_dc_block (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  snd_pkg::psg_t     psg,
    output snd_pkg::psg_ac_t  psg_ac
);
    import snd_pkg::*;

    logic        [$bits(psg_t)+DC_FRAC-1:0] avg;    // running average, DC_FRAC fraction bits
    logic signed [$bits(psg_t)+DC_FRAC:0]   diff;
    logic signed [$bits(psg_t)+DC_FRAC:0]   step;

    // distance from the scaled input to the average
    assign diff = $signed({1'b0, psg, {DC_FRAC{1'b0}}}) - $signed({1'b0, avg});

    // decay rate of 1/16 matches the fraction width
    assign step = diff >>> DC_FRAC;

    // integer part of the average comes off the live input
    assign psg_ac = $signed({1'b0, psg}) - $signed({1'b0, avg[$bits(avg)-1:DC_FRAC]});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            avg <= '0;
        end else if (cen) begin
            avg <= avg + step[$bits(avg)-1:0];   // stays between old avg and target
        end
    end

endmodule

// ==== verilog/snd_board.sv ====
`timescale 1ns/1ps

module snd_board #(
    parameter int ALT_FX = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen_opl,
    input  logic               cen_opn,
    // cpu side
    input  logic [7:0]         cpu_dout,
    input  logic               oki_wrn,
    output logic [7:0]         oki_dout,
    // adpcm sample rom
    output snd_pkg::rom_addr_t adpcm_addr,
    output logic               adpcm_cs,
    input  logic [7:0]         adpcm_data,
    input  logic               adpcm_ok,
    // synth chip outputs
    input  snd_pkg::sample_t   opn_snd,
    input  snd_pkg::sample_t   opl_snd,
    input  snd_pkg::psg_t      psg_snd,
    // mixer controls
    input  logic [1:0]         fxlevel,
    input  logic               enable_fm,
    input  logic               enable_psg,
    // mixed sound
    output snd_pkg::sample_t   snd,
    output logic               sample,
    output logic               peak
);
    import snd_pkg::*;

    logic    tick;
    nibble_t nib;
    logic    nib_valid;
    logic    restart;
    sample_t adpcm_snd;
    psg_ac_t psg_ac;

    adpcm_tick i_adpcm_tick (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen_opl (cen_opl),
        .tick    (tick)
    );

    adpcm_ctrl i_adpcm_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .cpu_dout   (cpu_dout),
        .oki_wrn    (oki_wrn),
        .oki_dout   (oki_dout),
        .adpcm_addr (adpcm_addr),
        .adpcm_cs   (adpcm_cs),
        .adpcm_data (adpcm_data),
        .adpcm_ok   (adpcm_ok),
        .nib        (nib),
        .nib_valid  (nib_valid),
        .restart    (restart)
    );

    adpcm_decoder i_adpcm_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .nib       (nib),
        .nib_valid (nib_valid),
        .restart   (restart),
        .adpcm_snd (adpcm_snd)
    );

    // psg dc removal paced by the opn enable
    psg_dc_block i_psg_dc_block (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen_opn),
        .psg    (psg_snd),
        .psg_ac (psg_ac)
    );

    snd_mixer #(
        .ALT_FX (ALT_FX)
    ) i_snd_mixer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen        (cen_opn),
        .opn_snd    (opn_snd),
        .opl_snd    (opl_snd),
        .adpcm_snd  (adpcm_snd),
        .psg_ac     (psg_ac),
        .fxlevel    (fxlevel),
        .enable_fm  (enable_fm),
        .enable_psg (enable_psg),
        .snd        (snd),
        .sample     (sample),
        .peak       (peak)
    );

endmodule

// ==== verilog/snd_mixer.sv ====
`timescale 1ns/1ps

module snd_mixer #(
    parameter int ALT_FX = 0   // 1 picks the alternate fx table
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    // channels
    input  snd_pkg::sample_t opn_snd,
    input  snd_pkg::sample_t opl_snd,
    input  snd_pkg::sample_t adpcm_snd,
    input  snd_pkg::psg_ac_t psg_ac,
    // controls
    input  logic [1:0]       fxlevel,
    input  logic             enable_fm,
    input  logic             enable_psg,
    // mixed output
    output snd_pkg::sample_t snd,
    output logic             sample,
    output logic             peak
);
    import snd_pkg::*;

    gain_t              fx_gain;
    sample_t            opn_in;
    sample_t            psg_in;
    logic signed [19:0] sum;       // headroom for 3x fx gain plus the rest
    logic               sat;
    sample_t            sum_sat;

    // channel times 4.4 gain, back to integer scale
    function automatic logic signed [19:0] scale(input sample_t x, input gain_t g);
        logic signed [24:0] prod;
        prod = x * $signed({1'b0, g});
        return 20'(prod >>> 4);
    endfunction

    always_comb begin
        if (ALT_FX != 0) begin
            fx_gain = FX_GAIN_ALT[fxlevel];
        end else begin
            fx_gain = FX_GAIN_STD[fxlevel];
        end
    end

    // channel masks
    assign opn_in = enable_fm  ? opn_snd          : '0;
    assign psg_in = enable_psg ? sample_t'(psg_ac) : '0;

    assign sum = scale(opn_in, fx_gain)
               + scale(opl_snd, OPL_GAIN)
               + scale(adpcm_snd, PCM_GAIN)
               + scale(psg_in, PSG_GAIN);

    // out of range unless the top bits all match the sign
    assign sat = ~((&sum[19:15]) | ~(|sum[19:15]));

    always_comb begin
        if (sat) begin
            sum_sat = {sum[19], {15{~sum[19]}}};   // clip to the rail
        end else begin
            sum_sat = sum[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            snd    <= '0;
            peak   <= 1'b0;
            sample <= 1'b0;
        end else begin
            sample <= cen;
            if (cen) begin
                snd  <= sum_sat;
                peak <= sat;
            end
        end
    end

endmodule
